// File: Bender.yml
package:
  name: fetch_stage

sources:
  - source/fetch_pkg.sv
  - source/fetch_target_select.sv
  - source/fetch_fip_reg.sv
  - source/fetch_itlb.sv
  - source/fetch_stage.sv
  - target: simulation
    files:
      - sim/fetch_stage_properties.sv
      - sim/fetch_stage_tb.sv

// File: fetch_stage.f
source/fetch_pkg.sv
source/fetch_target_select.sv
source/fetch_fip_reg.sv
source/fetch_itlb.sv
source/fetch_stage.sv
sim/fetch_stage_properties.sv
sim/fetch_stage_tb.sv

// File: sim/fetch_stage_properties.sv
`timescale 1ns/1ps

module fetch_stage_props
    import fetch_pkg::*;
(
    input logic       clk,
    input logic       rst_n_i,
    input cf_req_t    cf_req_i,
    input logic       ld_even_i,
    input logic       ld_odd_i,
    input fetch_out_t fetch_even_i,
    input fetch_out_t fetch_odd_i
);

    int unsigned fail_count = 0;  // read by the testbench at the end
    logic        cf_valid;

    assign cf_valid = |cf_req_i;

    ////////////////////////////////////////
    // sequential advance
    ////////////////////////////////////////

    // register content only shows when the next cycle has no redirect either
    even_step: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!cf_valid && ld_even_i) ##1 !cf_valid |->
        fetch_even_i.vline == line_t'($past(fetch_even_i.vline) + LINE_STEP))
    else begin
        $error("even bank did not advance by two lines after a load");
        fail_count = fail_count + 1;
    end

    odd_step: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!cf_valid && ld_odd_i) ##1 !cf_valid |->
        fetch_odd_i.vline == line_t'($past(fetch_odd_i.vline) + LINE_STEP))
    else begin
        $error("odd bank did not advance by two lines after a load");
        fail_count = fail_count + 1;
    end

    bank_parity: assert property (@(posedge clk) disable iff (!rst_n_i)
        !cf_valid |-> (!fetch_even_i.vline[0] && fetch_odd_i.vline[0]))
    else begin
        $error("a bank holds a line of the wrong parity");
        fail_count = fail_count + 1;
    end

    ////////////////////////////////////////
    // translation
    ////////////////////////////////////////

    miss_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!fetch_even_i.tlb_miss || fetch_even_i.pline == '0) &&
        (!fetch_odd_i.tlb_miss || fetch_odd_i.pline == '0))
    else begin
        $error("a TLB miss came with a nonzero physical line");
        fail_count = fail_count + 1;
    end

endmodule

bind fetch_stage fetch_stage_props u_props (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .cf_req_i     (cf_req_i),
    .ld_even_i    (ld_even_i),
    .ld_odd_i     (ld_odd_i),
    .fetch_even_i (fetch_even_o),
    .fetch_odd_i  (fetch_odd_o)
);

// File: sim/fetch_stage_tb.sv
`timescale 1ns/1ps

module fetch_stage_tb
    import fetch_pkg::*;
();

    localparam int unsigned SEED        = 32'h4997;
    localparam int unsigned RESET_LIMIT = 20;  // cycles

    localparam cf_req_t CF_NONE   = '{init: 1'b0, resteer: 1'b0, branch: 1'b0};
    localparam cf_req_t CF_INIT   = '{init: 1'b1, resteer: 1'b0, branch: 1'b0};
    localparam cf_req_t CF_ALL    = '{init: 1'b1, resteer: 1'b1, branch: 1'b1};
    localparam cf_req_t CF_RST    = '{init: 1'b0, resteer: 1'b1, branch: 1'b0};
    localparam cf_req_t CF_RST_BR = '{init: 1'b0, resteer: 1'b1, branch: 1'b1};
    localparam cf_req_t CF_BR     = '{init: 1'b0, resteer: 1'b0, branch: 1'b1};

    typedef struct packed {
        cf_req_t    cf;
        vaddr_t     init_addr;
        bank_pair_t wb;
        bank_pair_t bp;
        logic       ld_even;
        logic       ld_odd;
        fetch_out_t exp_even;
        fetch_out_t exp_odd;
    } row_t;

    logic                         clk;
    logic                         rst_n_i;
    cf_req_t                      cf_req_i;
    vaddr_t                       init_addr_i;
    bank_pair_t                   wb_fip_i;
    bank_pair_t                   bp_fip_i;
    logic                         ld_even_i;
    logic                         ld_odd_i;
    tlb_entry_t [TLB_ENTRIES-1:0] tlb_entries_i;
    fetch_out_t                   fetch_even_o;
    fetch_out_t                   fetch_odd_o;

    row_t        rows[$];
    int unsigned error_count = 0;
    int unsigned check_count = 0;

    fetch_stage dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .cf_req_i      (cf_req_i),
        .init_addr_i   (init_addr_i),
        .wb_fip_i      (wb_fip_i),
        .bp_fip_i      (bp_fip_i),
        .ld_even_i     (ld_even_i),
        .ld_odd_i      (ld_odd_i),
        .tlb_entries_i (tlb_entries_i),
        .fetch_even_o  (fetch_even_o),
        .fetch_odd_o   (fetch_odd_o)
    );

    always #2 clk = ~clk;  // 4 ns period

    initial begin
        clk     = 1'b0;
        rst_n_i = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_line(input string what, input line_t got, input line_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s vline is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pline(input string what, input pline_t got, input pline_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s pline is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_miss(input string what, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s tlb_miss is %b, expected %b", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    function automatic bank_pair_t make_pair(input line_t even, input line_t odd);
        return '{even: even, odd: odd};
    endfunction

    task automatic add_row(input cf_req_t cf, input vaddr_t init_addr,
                           input bank_pair_t wb, input bank_pair_t bp,
                           input logic ld_e, input logic ld_o,
                           input line_t ev, input pline_t ep, input logic em,
                           input line_t ov, input pline_t op, input logic om);
        row_t r;
        r = '{cf: cf, init_addr: init_addr, wb: wb, bp: bp, ld_even: ld_e, ld_odd: ld_o,
              exp_even: '{vline: ev, pline: ep, tlb_miss: em},
              exp_odd: '{vline: ov, pline: op, tlb_miss: om}};
        rows.push_back(r);
    endtask

    // page 0x00000 -> frame 0x00005, page 0x00012 -> frame 0x0abc3, page 0x00034 absent
    task automatic load_tlb();
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            tlb_entries_i[i].vpage   = page_t'(32'hf0000 + i);
            tlb_entries_i[i].pframe  = page_t'($urandom);  // unused, never hits
            tlb_entries_i[i].valid   = 1'b0;
            tlb_entries_i[i].present = 1'b0;
        end
        tlb_entries_i[0] = '{vpage: 'h00000, pframe: 'h00005, valid: 1'b1, present: 1'b1};
        tlb_entries_i[1] = '{vpage: 'h00012, pframe: 'h0abc3, valid: 1'b1, present: 1'b1};
        tlb_entries_i[2] = '{vpage: 'h00034, pframe: 'h00777, valid: 1'b1, present: 1'b0};
    endtask

    task automatic build_table();
        bank_pair_t absent;
        bank_pair_t unmapped;
        absent   = make_pair('h3400, 'h3401);
        unmapped = make_pair('h7700, 'h7701);
        // reset values, then sequential loads per bank
        add_row(CF_NONE, '0, '0, '0, 0, 0, 'h0000, 'h500, 0, 'h0001, 'h501, 0);
        add_row(CF_NONE, '0, '0, '0, 1, 1, 'h0000, 'h500, 0, 'h0001, 'h501, 0);
        add_row(CF_NONE, '0, '0, '0, 1, 0, 'h0002, 'h502, 0, 'h0003, 'h503, 0);
        add_row(CF_NONE, '0, '0, '0, 0, 1, 'h0004, 'h504, 0, 'h0003, 'h503, 0);
        add_row(CF_NONE, '0, '0, '0, 0, 0, 'h0004, 'h504, 0, 'h0005, 'h505, 0);
        // init on an even line, then on an odd line together with loads
        add_row(CF_INIT, 'h0001_2340, '0, '0, 0, 0, 'h1234, 'h334, 0, 'h1235, 'h335, 0);
        add_row(CF_INIT, 'h0001_2570, '0, '0, 1, 1, 'h1258, 'h358, 0, 'h1257, 'h357, 0);
        add_row(CF_NONE, '0, '0, '0, 0, 0, 'h125a, 'h35a, 0, 'h1259, 'h359, 0);
        // priority, the absent and unmapped pages miss
        add_row(CF_ALL, 'h0000_0100, absent, unmapped, 0, 0,
                'h0010, 'h510, 0, 'h0011, 'h511, 0);
        add_row(CF_RST_BR, 'h0000_0100, absent, unmapped, 0, 0,
                'h3400, '0, 1, 'h3401, '0, 1);
        add_row(CF_BR, 'h0000_0100, absent, unmapped, 0, 0, 'h7700, '0, 1, 'h7701, '0, 1);
        add_row(CF_RST, '0, make_pair('h12f0, 'h12f1), unmapped, 1, 1,
                'h12f0, 'h3f0, 0, 'h12f1, 'h3f1, 0);
        add_row(CF_NONE, '0, '0, '0, 1, 0, 'h12f2, 'h3f2, 0, 'h12f3, 'h3f3, 0);
        add_row(CF_NONE, '0, '0, '0, 0, 0, 'h12f4, 'h3f4, 0, 'h12f3, 'h3f3, 0);
        // loads carry both banks into the next page, which is unmapped
        add_row(CF_BR, '0, absent, make_pair('h12fe, 'h12ff), 1, 1,
                'h12fe, 'h3fe, 0, 'h12ff, 'h3ff, 0);
        add_row(CF_NONE, '0, '0, '0, 0, 0, 'h1300, '0, 1, 'h1301, '0, 1);
    endtask

    task automatic apply_row(input int idx);
        row_t        r;
        int unsigned errors_before;
        r             = rows[idx];
        errors_before = error_count;
        @(negedge clk);
        cf_req_i    = r.cf;
        init_addr_i = r.init_addr;
        wb_fip_i    = r.wb;
        bp_fip_i    = r.bp;
        ld_even_i   = r.ld_even;
        ld_odd_i    = r.ld_odd;
        #1;  // one ns ahead of the rising edge
        check_line($sformatf("row %0d even", idx), fetch_even_o.vline, r.exp_even.vline);
        check_pline($sformatf("row %0d even", idx), fetch_even_o.pline, r.exp_even.pline);
        check_miss($sformatf("row %0d even", idx), fetch_even_o.tlb_miss, r.exp_even.tlb_miss);
        check_line($sformatf("row %0d odd", idx), fetch_odd_o.vline, r.exp_odd.vline);
        check_pline($sformatf("row %0d odd", idx), fetch_odd_o.pline, r.exp_odd.pline);
        check_miss($sformatf("row %0d odd", idx), fetch_odd_o.tlb_miss, r.exp_odd.tlb_miss);
        if (error_count == errors_before) begin
            $display("row %0d: ok", idx);
        end else begin
            $display("row %0d: mismatch", idx);
        end
    endtask

    task automatic report();
        int unsigned prop_fails;
        prop_fails = dut.u_props.fail_count;
        $display("rows %0d, checks %0d, errors %0d, assertion failures %0d",
                 rows.size(), check_count, error_count, prop_fails);
        if (error_count == 0 && prop_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    initial begin
        int unsigned waited;
        void'($urandom(SEED));
        cf_req_i    = CF_NONE;
        init_addr_i = '0;
        wb_fip_i    = '0;
        bp_fip_i    = '0;
        ld_even_i   = 1'b0;
        ld_odd_i    = 1'b0;
        load_tlb();
        build_table();
        waited = 0;
        // reset may still be unknown at time zero
        while (rst_n_i !== 1'b1 && waited < RESET_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n_i !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            foreach (rows[i]) begin
                apply_row(i);
            end
            @(negedge clk);
            cf_req_i  = CF_NONE;
            ld_even_i = 1'b0;
            ld_odd_i  = 1'b0;
            repeat (2) @(negedge clk);  // let the last assertions sample
            report();
        end
    end

endmodule

// File: source/fetch_fip_reg.sv
`timescale 1ns/1ps

module fetch_fip_reg
    import fetch_pkg::*;
#(
    parameter int unsigned PARITY = 0  // 0 even bank, 1 odd bank
) (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  cf_valid_i,
    input  line_t cf_line_i,
    input  logic  ld_i,
    output line_t vline_o
);

    localparam line_t RST_LINE = line_t'(PARITY);  // first line of this bank

    line_t fip_q;
    line_t fip_next;

    ////////////////////////////////////////
    // current line
    ////////////////////////////////////////

    // a redirect shows up in the same cycle
    assign vline_o = cf_valid_i ? cf_line_i : fip_q;

    // step past the partner bank's line
    // parity is kept since the step is even
    assign fip_next = vline_o + line_t'(LINE_STEP);

    ////////////////////////////////////////
    // next sequential line
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fip_q <= RST_LINE;
        end else if (ld_i) begin
            fip_q <= fip_next;  // latch took vline_o this cycle
        end
    end

endmodule

// File: source/fetch_itlb.sv
`timescale 1ns/1ps

module fetch_itlb
    import fetch_pkg::*;
(
    input  line_t                        vline_i,
    input  tlb_entry_t [TLB_ENTRIES-1:0] tlb_entries_i,
    output fetch_out_t                   fetch_o
);

    page_t                  vpage;
    logic [TLB_ENTRIES-1:0] hit_vec;
    logic                   hit;
    page_t                  pframe;

    ////////////////////////////////////////
    // tag compare
    ////////////////////////////////////////

    assign vpage = vline_i[LINE_W-1:LINES_PER_PAGE_W];

    // an entry counts only if it is valid and its page is present
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit_vec[i] = tlb_entries_i[i].valid
                       & tlb_entries_i[i].present
                       & (tlb_entries_i[i].vpage == vpage);
        end
    end

    // walk down so the lowest index wins on multiple hits
    always_comb begin
        hit    = 1'b0;
        pframe = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit    = 1'b1;
                pframe = tlb_entries_i[i].pframe;
            end
        end
    end

    ////////////////////////////////////////
    // result
    ////////////////////////////////////////

    assign fetch_o.vline    = vline_i;
    assign fetch_o.tlb_miss = ~hit;

    // frame low bits on top of the line offset within the page
    assign fetch_o.pline = hit
        ? {pframe[PFN_LOW_W-1:0], vline_i[LINES_PER_PAGE_W-1:0]}
        : '0;

endmodule

// File: source/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////
    // address geometry
    ////////////////////////////////////////

    localparam int unsigned BYTE_OFF_W       = 4;   // 16-byte fetch lines
    localparam int unsigned LINE_W           = 28;
    localparam int unsigned VADDR_W          = LINE_W + BYTE_OFF_W;
    localparam int unsigned PAGE_W           = 20;  // 4 KiB pages
    localparam int unsigned LINES_PER_PAGE_W = 8;
    localparam int unsigned PADDR_W          = 11;

    // page frame bits kept in the physical line
    localparam int unsigned PFN_LOW_W        = PADDR_W - LINES_PER_PAGE_W;

    localparam int unsigned TLB_ENTRIES      = 8;

    // each bank only ever sees every other line
    localparam int unsigned LINE_STEP        = 2;

    typedef logic [LINE_W-1:0]  line_t;   // virtual line address
    typedef logic [VADDR_W-1:0] vaddr_t;  // virtual byte address
    typedef logic [PAGE_W-1:0]  page_t;   // virtual page or page frame
    typedef logic [PADDR_W-1:0] pline_t;  // physical line address

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////

    typedef struct packed {
        page_t vpage;
        page_t pframe;
        logic  valid;
        logic  present;
    } tlb_entry_t;

    typedef struct packed {
        line_t even;
        line_t odd;
    } bank_pair_t;

    // control-flow strobes, highest priority first
    typedef struct packed {
        logic init;
        logic resteer;  // from writeback
        logic branch;   // from the predictor
    } cf_req_t;

    typedef struct packed {
        line_t  vline;
        pline_t pline;
        logic   tlb_miss;
    } fetch_out_t;

endpackage

// File: source/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import fetch_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  cf_req_t                      cf_req_i,
    input  vaddr_t                       init_addr_i,
    input  bank_pair_t                   wb_fip_i,
    input  bank_pair_t                   bp_fip_i,
    input  logic                         ld_even_i,  // even fetch latch loaded
    input  logic                         ld_odd_i,   // odd fetch latch loaded
    input  tlb_entry_t [TLB_ENTRIES-1:0] tlb_entries_i,
    output fetch_out_t                   fetch_even_o,
    output fetch_out_t                   fetch_odd_o
);

    logic       cf_valid;
    bank_pair_t cf_target;
    line_t      vline_even;
    line_t      vline_odd;

    ////////////////////////////////////////
    // target selection
    ////////////////////////////////////////

    fetch_target_select u_target_select (
        .cf_req_i    (cf_req_i),
        .init_addr_i (init_addr_i),
        .wb_fip_i    (wb_fip_i),
        .bp_fip_i    (bp_fip_i),
        .cf_valid_o  (cf_valid),
        .cf_target_o (cf_target)
    );

    ////////////////////////////////////////
    // per-bank FIP
    ////////////////////////////////////////

    fetch_fip_reg #(.PARITY(0)) u_fip_even (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .cf_valid_i (cf_valid),
        .cf_line_i  (cf_target.even),
        .ld_i       (ld_even_i),
        .vline_o    (vline_even)
    );

    fetch_fip_reg #(.PARITY(1)) u_fip_odd (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .cf_valid_i (cf_valid),
        .cf_line_i  (cf_target.odd),
        .ld_i       (ld_odd_i),
        .vline_o    (vline_odd)
    );

    // translation, one lookup port per bank
    fetch_itlb u_itlb_even (
        .vline_i       (vline_even),
        .tlb_entries_i (tlb_entries_i),
        .fetch_o       (fetch_even_o)
    );

    fetch_itlb u_itlb_odd (
        .vline_i       (vline_odd),
        .tlb_entries_i (tlb_entries_i),
        .fetch_o       (fetch_odd_o)
    );

endmodule

// File: source/fetch_target_select.sv
`timescale 1ns/1ps

module fetch_target_select
    import fetch_pkg::*;
(
    input  cf_req_t    cf_req_i,
    input  vaddr_t     init_addr_i,
    input  bank_pair_t wb_fip_i,
    input  bank_pair_t bp_fip_i,
    output logic       cf_valid_o,
    output bank_pair_t cf_target_o
);

    line_t      init_line;
    line_t      init_line_inc;
    bank_pair_t init_pair;

    ////////////////////////////////////////
    // init address split
    ////////////////////////////////////////

    assign init_line     = init_addr_i[VADDR_W-1:BYTE_OFF_W]; // drop byte offset
    assign init_line_inc = init_line + line_t'(1);

    // the requested line goes to its own bank, the partner fetches the next one
    always_comb begin
        if (init_line[0]) begin
            init_pair.odd  = init_line;
            init_pair.even = init_line_inc;
        end else begin
            init_pair.even = init_line;
            init_pair.odd  = init_line_inc;
        end
    end

    ////////////////////////////////////////
    // priority select
    ////////////////////////////////////////

    assign cf_valid_o = cf_req_i.init | cf_req_i.resteer | cf_req_i.branch;

    always_comb begin
        if (cf_req_i.init) begin
            cf_target_o = init_pair;
        end else if (cf_req_i.resteer) begin
            cf_target_o = wb_fip_i;   // writeback resteer beats prediction
        end else begin
            cf_target_o = bp_fip_i;   // also the idle value, masked by cf_valid_o
        end
    end

endmodule
